// ==== mips_defs.svh ====
// ISA widths, opcodes and funct codes for the pipelined MIPS core
// included by the package, the RTL and the testbench
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////
`define MIPS_XLEN       32              // data and address width
`define MIPS_REG_AW     5               // register index width
`define MIPS_NREGS      32              // architectural registers
`define MIPS_OP_W       6               // opcode and funct field width

////////////////////////////////////////////////////////////
// opcodes, instr[31:26]
////////////////////////////////////////////////////////////
`define MIPS_OP_RTYPE   6'b000000       // alu ops, selected by funct
`define MIPS_OP_LW      6'b100011       // load word
`define MIPS_OP_SW      6'b101011       // store word
`define MIPS_OP_ADDI    6'b001000       // add immediate

////////////////////////////////////////////////////////////
// funct codes, instr[5:0]
////////////////////////////////////////////////////////////
`define MIPS_FN_AND     6'b100100       // bitwise and
`define MIPS_FN_OR      6'b100101       // bitwise or
`define MIPS_FN_ADD     6'b100000       // add
`define MIPS_FN_SUB     6'b100010       // subtract
`define MIPS_FN_SLT     6'b101010       // signed set less than

`endif

// ==== mips_pkg.sv ====
// types shared by the MIPS core: alu op, forward select, control word,
// stage registers and the hazard result
`default_nettype none

`include "mips_defs.svh"

package mips_pkg;

	// alu operation, carried in the control word
	typedef enum logic [2:0] {
		alu_and = 3'd0,                         // also the no-op encoding
		alu_or  = 3'd1,
		alu_add = 3'd2,
		alu_sub = 3'd3,
		alu_slt = 3'd4                          // signed compare
	} alu_op_e;

	// source of an execute operand
	typedef enum logic [1:0] {
		fwd_rf = 2'b00,                         // value read in decode
		fwd_w  = 2'b01,                         // result in writeback
		fwd_m  = 2'b10                          // alu result in memory
	} fwd_sel_e;

	typedef struct packed {
		logic    regwrite;                      // writes a register
		logic    memtoreg;                      // result from dmem (lw)
		logic    memwrite;                      // writes dmem (sw)
		logic    alusrc;                        // operand b is the immediate
		logic    regdst;                        // dest is rd, else rt
		alu_op_e alu_op;
	} ctrl_t;                                   // 8 bits

	typedef struct packed {
		ctrl_t                   ctrl;
		logic [`MIPS_XLEN-1:0]   rd1;           // rs contents
		logic [`MIPS_XLEN-1:0]   rd2;           // rt contents
		logic [`MIPS_REG_AW-1:0] rs;
		logic [`MIPS_REG_AW-1:0] rt;
		logic [`MIPS_REG_AW-1:0] rd;
		logic [`MIPS_XLEN-1:0]   signimm;       // sign extended imm
	} de_reg_t;                                 // 119 bits

	typedef struct packed {
		logic                    regwrite;
		logic                    memtoreg;
		logic                    memwrite;
		logic [`MIPS_XLEN-1:0]   aluout;        // also the dmem address
		logic [`MIPS_XLEN-1:0]   writedata;     // store data
		logic [`MIPS_REG_AW-1:0] writereg;
	} em_reg_t;                                 // 72 bits

	typedef struct packed {
		logic                    regwrite;
		logic                    memtoreg;
		logic [`MIPS_XLEN-1:0]   readdata;      // dmem word
		logic [`MIPS_XLEN-1:0]   aluout;
		logic [`MIPS_REG_AW-1:0] writereg;
	} mw_reg_t;                                 // 71 bits

	typedef struct packed {
		logic     stall;                        // hold pc and decode reg
		logic     flush;                        // bubble into execute
		fwd_sel_e fwd_a;                        // operand a source
		fwd_sel_e fwd_b;                        // operand b / store data source
	} hazard_t;                                 // 6 bits

endpackage

`default_nettype wire

// ==== instr_decoder.sv ====
// decode-stage control: opcode and funct to a control word
// unknown encodings give the all-zero no-op word
`default_nettype none

`include "mips_defs.svh"

module instr_decoder (
	input  wire logic [`MIPS_OP_W-1:0] op,     // instr[31:26] in decode
	input  wire logic [`MIPS_OP_W-1:0] funct,  // instr[5:0] in decode
	output mips_pkg::ctrl_t            ctrl_d  // control word in decode
);

	import mips_pkg::*;

	// main decode and alu decode in one case tree
	always_comb begin
		ctrl_d = '0;                            // no-op unless recognised
		case (op)
			`MIPS_OP_RTYPE: begin
				ctrl_d.regwrite = 1'b1;         // writes rd
				ctrl_d.regdst   = 1'b1;
				case (funct)
					`MIPS_FN_AND: ctrl_d.alu_op = alu_and;
					`MIPS_FN_OR:  ctrl_d.alu_op = alu_or;
					`MIPS_FN_ADD: ctrl_d.alu_op = alu_add;
					`MIPS_FN_SUB: ctrl_d.alu_op = alu_sub;
					`MIPS_FN_SLT: ctrl_d.alu_op = alu_slt;
					default:      ctrl_d = '0;  // bad funct, drop the write
				endcase
			end
			`MIPS_OP_LW: begin
				ctrl_d.regwrite = 1'b1;         // writes rt
				ctrl_d.memtoreg = 1'b1;         // result from dmem
				ctrl_d.alusrc   = 1'b1;         // base + offset
				ctrl_d.alu_op   = alu_add;
			end
			`MIPS_OP_SW: begin
				ctrl_d.memwrite = 1'b1;
				ctrl_d.alusrc   = 1'b1;         // base + offset
				ctrl_d.alu_op   = alu_add;
			end
			`MIPS_OP_ADDI: begin
				ctrl_d.regwrite = 1'b1;         // writes rt
				ctrl_d.alusrc   = 1'b1;
				ctrl_d.alu_op   = alu_add;
			end
			default: ctrl_d = '0;               // undefined opcode
		endcase
	end

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
// load-use stall, execute flush and execute forward selects
`default_nettype none

`include "mips_defs.svh"

module hazard_unit (
	input  wire logic [`MIPS_REG_AW-1:0] rs_d,       // sources in decode
	input  wire logic [`MIPS_REG_AW-1:0] rt_d,
	input  wire logic [`MIPS_REG_AW-1:0] rs_e,       // sources in execute
	input  wire logic [`MIPS_REG_AW-1:0] rt_e,
	input  wire logic [`MIPS_REG_AW-1:0] writereg_e, // lw dest in execute
	input  wire logic                    memtoreg_e, // lw in execute
	input  wire logic [`MIPS_REG_AW-1:0] writereg_m,
	input  wire logic                    regwrite_m,
	input  wire logic [`MIPS_REG_AW-1:0] writereg_w,
	input  wire logic                    regwrite_w,
	output mips_pkg::hazard_t            haz
);

	import mips_pkg::*;

	logic lw_stall;                             // load-use in decode vs execute

	// memory beats writeback, register 0 never forwards
	function automatic fwd_sel_e fwd_pick(
		input logic [`MIPS_REG_AW-1:0] src,
		input logic [`MIPS_REG_AW-1:0] wr_m,
		input logic                    we_m,
		input logic [`MIPS_REG_AW-1:0] wr_w,
		input logic                    we_w
	);
		if (src != '0 && we_m && src == wr_m)
			return fwd_m;
		if (src != '0 && we_w && src == wr_w)
			return fwd_w;
		return fwd_rf;
	endfunction

	assign lw_stall = memtoreg_e && (writereg_e != '0) &&
		(writereg_e == rs_d || writereg_e == rt_d);  // load data not ready yet

	always_comb begin
		haz.stall = lw_stall;                   // pc and decode reg hold
		haz.flush = lw_stall;                   // execute gets a bubble
		haz.fwd_a = fwd_pick(rs_e, writereg_m, regwrite_m, writereg_w, regwrite_w);
		haz.fwd_b = fwd_pick(rt_e, writereg_m, regwrite_m, writereg_w, regwrite_w);
	end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
// 32 x 32 register file, r0 reads zero, same-cycle write bypassed to reads
`default_nettype none

`include "mips_defs.svh"

module reg_file (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    we,  // write enable from writeback
	input  wire logic [`MIPS_REG_AW-1:0] ra1, // rs
	input  wire logic [`MIPS_REG_AW-1:0] ra2, // rt
	input  wire logic [`MIPS_REG_AW-1:0] wa,
	input  wire logic [`MIPS_XLEN-1:0]   wd,
	output logic      [`MIPS_XLEN-1:0]   rd1,
	output logic      [`MIPS_XLEN-1:0]   rd2
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];
	logic                  wr_ok;             // write to a real register

	assign wr_ok = we && (wa != '0);          // r0 stays zero

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MIPS_NREGS; i++)
				regs[i] <= '0;
		end else if (wr_ok) begin
			regs[wa] <= wd;
		end
	end

	assign rd1 = (wr_ok && wa == ra1) ? wd : regs[ra1];  // write before read
	assign rd2 = (wr_ok && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// ==== pipeline_datapath.sv ====
// five-stage datapath: pc, stage registers, forwarding, alu, write-back
// control comes from instr_decoder, stall/flush/forwarding from hazard_unit
`default_nettype none

`include "mips_defs.svh"

module pipeline_datapath (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic [`MIPS_XLEN-1:0]   instr_f,    // imem word at pc_f
	input  wire logic [`MIPS_XLEN-1:0]   readdata_m, // dmem word at aluout_m
	input  mips_pkg::ctrl_t              ctrl_d,
	input  mips_pkg::hazard_t            haz,
	output logic      [`MIPS_OP_W-1:0]   op_d,
	output logic      [`MIPS_OP_W-1:0]   funct_d,
	output logic      [`MIPS_REG_AW-1:0] rs_d,
	output logic      [`MIPS_REG_AW-1:0] rt_d,
	output logic      [`MIPS_REG_AW-1:0] rs_e,
	output logic      [`MIPS_REG_AW-1:0] rt_e,
	output logic      [`MIPS_REG_AW-1:0] writereg_e,
	output logic                         memtoreg_e,
	output logic      [`MIPS_REG_AW-1:0] writereg_m,
	output logic                         regwrite_m,
	output logic      [`MIPS_REG_AW-1:0] writereg_w,
	output logic                         regwrite_w,
	output logic      [`MIPS_XLEN-1:0]   pc_f,
	output logic                         memwrite_m,
	output logic      [`MIPS_XLEN-1:0]   aluout_m,
	output logic      [`MIPS_XLEN-1:0]   writedata_m,
	output logic      [`MIPS_XLEN-1:0]   result_w
);

	import mips_pkg::*;

	logic [`MIPS_XLEN-1:0] instr_d;             // decode register
	logic [`MIPS_XLEN-1:0] rd1_d, rd2_d;        // register file reads
	logic [`MIPS_XLEN-1:0] signimm_d;
	logic [`MIPS_XLEN-1:0] srca_e, srcb_e;      // alu operands
	logic [`MIPS_XLEN-1:0] writedata_e;         // forwarded rt, store data
	logic [`MIPS_XLEN-1:0] aluout_e;
	de_reg_t               de_d, de_q;
	em_reg_t               em_d, em_q;
	mw_reg_t               mw_d, mw_q;

	// picks the operand from register file, writeback or memory
	function automatic logic [`MIPS_XLEN-1:0] fwd_mux(
		input fwd_sel_e              sel,
		input logic [`MIPS_XLEN-1:0] rf_val,
		input logic [`MIPS_XLEN-1:0] w_val,
		input logic [`MIPS_XLEN-1:0] m_val
	);
		case (sel)
			fwd_m:   return m_val;
			fwd_w:   return w_val;
			default: return rf_val;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// fetch and decode
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_f    <= '0;
			instr_d <= '0;                      // zero word decodes as no-op
		end else if (!haz.stall) begin          // both hold on load-use
			pc_f    <= pc_f + 4;
			instr_d <= instr_f;
		end
	end

	assign op_d      = instr_d[31:26];
	assign funct_d   = instr_d[5:0];
	assign rs_d      = instr_d[25:21];
	assign rt_d      = instr_d[20:16];
	assign signimm_d = {{16{instr_d[15]}}, instr_d[15:0]};

	reg_file reg_file_inst (
		.clk (clk),
		.rst (rst),
		.we  (mw_q.regwrite),
		.ra1 (rs_d),
		.ra2 (rt_d),
		.wa  (mw_q.writereg),
		.wd  (result_w),
		.rd1 (rd1_d),
		.rd2 (rd2_d)
	);

	assign de_d = '{ctrl: ctrl_d, rd1: rd1_d, rd2: rd2_d, rs: rs_d, rt: rt_d,
		rd: instr_d[15:11], signimm: signimm_d};

	////////////////////////////////////////////////////////////
	// execute
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst || haz.flush)
			de_q <= '0;                         // no-op bubble
		else
			de_q <= de_d;
	end

	assign rs_e        = de_q.rs;
	assign rt_e        = de_q.rt;
	assign memtoreg_e  = de_q.ctrl.memtoreg;
	assign writereg_e  = de_q.ctrl.regdst ? de_q.rd : de_q.rt;
	assign srca_e      = fwd_mux(haz.fwd_a, de_q.rd1, result_w, em_q.aluout);
	assign writedata_e = fwd_mux(haz.fwd_b, de_q.rd2, result_w, em_q.aluout);
	assign srcb_e      = de_q.ctrl.alusrc ? de_q.signimm : writedata_e;

	always_comb begin
		case (de_q.ctrl.alu_op)
			alu_and: aluout_e = srca_e & srcb_e;
			alu_or:  aluout_e = srca_e | srcb_e;
			alu_add: aluout_e = srca_e + srcb_e;
			alu_sub: aluout_e = srca_e - srcb_e;
			alu_slt: aluout_e = ($signed(srca_e) < $signed(srcb_e)) ? 32'd1 : 32'd0;
			default: aluout_e = '0;
		endcase
	end

	assign em_d = '{regwrite: de_q.ctrl.regwrite, memtoreg: de_q.ctrl.memtoreg,
		memwrite: de_q.ctrl.memwrite, aluout: aluout_e, writedata: writedata_e,
		writereg: writereg_e};

	////////////////////////////////////////////////////////////
	// memory and writeback
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			em_q <= '0;
			mw_q <= '0;
		end else begin
			em_q <= em_d;
			mw_q <= mw_d;
		end
	end

	assign memwrite_m  = em_q.memwrite;
	assign aluout_m    = em_q.aluout;           // dmem address
	assign writedata_m = em_q.writedata;
	assign writereg_m  = em_q.writereg;
	assign regwrite_m  = em_q.regwrite;

	assign mw_d = '{regwrite: em_q.regwrite, memtoreg: em_q.memtoreg,
		readdata: readdata_m, aluout: em_q.aluout, writereg: em_q.writereg};

	assign writereg_w = mw_q.writereg;
	assign regwrite_w = mw_q.regwrite;
	assign result_w   = mw_q.memtoreg ? mw_q.readdata : mw_q.aluout;  // lw or alu

endmodule

`default_nettype wire

// ==== mips_pipeline.sv ====
// top of the pipelined MIPS core, imem and dmem sit outside
// instr_f and readdata_m must answer within the same cycle
`default_nettype none

`include "mips_defs.svh"

module mips_pipeline (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic [`MIPS_XLEN-1:0] instr_f,     // word at pc_f
	input  wire logic [`MIPS_XLEN-1:0] readdata_m,  // word at aluout_m
	output logic      [`MIPS_XLEN-1:0] pc_f,
	output logic                       memwrite_m,  // sw in memory stage
	output logic      [`MIPS_XLEN-1:0] aluout_m,    // dmem address
	output logic      [`MIPS_XLEN-1:0] writedata_m, // store data
	output logic      [`MIPS_XLEN-1:0] result_w     // write-back value
);

	import mips_pkg::*;

	ctrl_t                   ctrl_d;            // decoder to datapath
	hazard_t                 haz;               // hazard unit to datapath
	logic [`MIPS_OP_W-1:0]   op_d, funct_d;
	logic [`MIPS_REG_AW-1:0] rs_d, rt_d, rs_e, rt_e;
	logic [`MIPS_REG_AW-1:0] writereg_e, writereg_m, writereg_w;
	logic                    memtoreg_e, regwrite_m, regwrite_w;

	instr_decoder instr_decoder_inst (
		.op     (op_d),
		.funct  (funct_d),
		.ctrl_d (ctrl_d)
	);

	hazard_unit hazard_unit_inst (
		.rs_d       (rs_d),
		.rt_d       (rt_d),
		.rs_e       (rs_e),
		.rt_e       (rt_e),
		.writereg_e (writereg_e),
		.memtoreg_e (memtoreg_e),
		.writereg_m (writereg_m),
		.regwrite_m (regwrite_m),
		.writereg_w (writereg_w),
		.regwrite_w (regwrite_w),
		.haz        (haz)
	);

	pipeline_datapath pipeline_datapath_inst (
		.clk         (clk),
		.rst         (rst),
		.instr_f     (instr_f),
		.readdata_m  (readdata_m),
		.ctrl_d      (ctrl_d),
		.haz         (haz),
		.op_d        (op_d),
		.funct_d     (funct_d),
		.rs_d        (rs_d),
		.rt_d        (rt_d),
		.rs_e        (rs_e),
		.rt_e        (rt_e),
		.writereg_e  (writereg_e),
		.memtoreg_e  (memtoreg_e),
		.writereg_m  (writereg_m),
		.regwrite_m  (regwrite_m),
		.writereg_w  (writereg_w),
		.regwrite_w  (regwrite_w),
		.pc_f        (pc_f),
		.memwrite_m  (memwrite_m),
		.aluout_m    (aluout_m),
		.writedata_m (writedata_m),
		.result_w    (result_w)
	);

endmodule

`default_nettype wire

// ==== mips_checker.sv ====
// watches the core's ports and compares reset state, pc steps, stores and write-back values
// the testbench loads the expected stores and register results through two tasks
`default_nettype none

`include "mips_defs.svh"

module mips_checker (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic [`MIPS_XLEN-1:0] pc_f,
	input  wire logic [`MIPS_XLEN-1:0] instr_f,
	input  wire logic                  memwrite_m,
	input  wire logic [`MIPS_XLEN-1:0] aluout_m,
	input  wire logic [`MIPS_XLEN-1:0] writedata_m,
	input  wire logic [`MIPS_XLEN-1:0] result_w,
	output int                         stores_seen,
	output int                         stores_expected
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] exp_addr_q [$];               // model stores in program order
	logic [31:0] exp_data_q [$];
	logic [31:0] exp_res_q [$];                // model register results in program order
	int          n_seen        = 0;
	int          n_expected    = 0;
	int          reset_checks  = 0;
	int          reset_fails   = 0;
	int          pc_checks     = 0;
	int          pc_fails      = 0;
	int          store_fails   = 0;
	int          result_checks = 0;
	int          result_fails  = 0;
	int          cyc           = 0;            // cycles since reset release
	logic [31:0] instr_d       = '0;           // shadow of decode stage
	logic [31:0] instr_e       = '0;           // shadow of execute stage
	logic [31:0] instr_m       = '0;           // shadow of memory stage
	logic [31:0] instr_w       = '0;           // shadow of writeback stage
	logic [31:0] prev_pc       = '0;
	logic        prev_stall    = 1'b0;
	logic        have_prev     = 1'b0;
	logic        stall;
	logic [31:0] exp_pc, exp_addr, exp_data, exp_res;

	assign stores_seen     = n_seen;
	assign stores_expected = n_expected;

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
		n_expected++;
	endtask

	task automatic push_result(input logic [31:0] value);
		exp_res_q.push_back(value);
	endtask

	// lw in execute whose nonzero rt matches rs or rt of the word in decode
	function automatic logic load_use(input logic [31:0] d, input logic [31:0] e);
		if (e[31:26] != `MIPS_OP_LW || e[20:16] == 5'd0)
			return 1'b0;
		return (e[20:16] == d[25:21]) || (e[20:16] == d[20:16]);
	endfunction

	// lw, addi and the five r-type alu ops write a register
	function automatic logic writes_reg(input logic [31:0] w);
		if (w[31:26] == `MIPS_OP_LW || w[31:26] == `MIPS_OP_ADDI)
			return 1'b1;
		if (w[31:26] != `MIPS_OP_RTYPE)
			return 1'b0;
		case (w[5:0])
			`MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_ADD, `MIPS_FN_SUB, `MIPS_FN_SLT:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic string verdict(input int fails);
		return (fails == 0) ? "ok" : "failed";
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			instr_d   = '0;
			instr_e   = '0;
			instr_m   = '0;
			instr_w   = '0;
			have_prev = 1'b0;
			cyc       = 0;
		end else begin
			////////////////////////////////////////////////////////////
			// reset state over the first three cycles
			////////////////////////////////////////////////////////////
			if (cyc == 0) begin
				reset_checks++;
				if (pc_f !== 32'd0) begin
					reset_fails++;
					$display("FAIL pc_f: got 0x%08h, expected 0x%08h", pc_f, 32'd0);
				end
			end
			if (cyc < 3) begin                 // no store can be in memory yet
				reset_checks++;
				if (memwrite_m !== 1'b0) begin
					reset_fails++;
					$display("FAIL memwrite_m: got 0x%0h, expected 0x0", memwrite_m);
				end
			end
			if (cyc == 2)
				$display("test reset       : %s, %0d checks", verdict(reset_fails), reset_checks);
			// pc steps by 4 and holds one cycle on load-use
			if (have_prev) begin
				pc_checks++;
				exp_pc = prev_stall ? prev_pc : prev_pc + 32'd4;
				if (pc_f !== exp_pc) begin
					pc_fails++;
					$display("FAIL pc_f: got 0x%08h, expected 0x%08h", pc_f, exp_pc);
				end
			end
			// store stream against the model queue
			if (memwrite_m === 1'b1) begin
				n_seen++;
				if (exp_addr_q.size() == 0) begin
					store_fails++;
					$display("store to 0x%08h seen after the model ran out of stores", aluout_m);
				end else begin
					exp_addr = exp_addr_q.pop_front();
					exp_data = exp_data_q.pop_front();
					if (aluout_m !== exp_addr) begin
						store_fails++;
						$display("FAIL aluout_m: got 0x%08h, expected 0x%08h", aluout_m, exp_addr);
					end
					if (writedata_m !== exp_data) begin
						store_fails++;
						$display("FAIL writedata_m: got 0x%08h, expected 0x%08h",
							writedata_m, exp_data);
					end
				end
			end else if (memwrite_m !== 1'b0) begin
				store_fails++;
				$display("memwrite_m is unknown while pc_f is 0x%08h", pc_f);
			end
			// write-back value of every register-writing instruction
			if (writes_reg(instr_w)) begin
				result_checks++;
				if (exp_res_q.size() == 0) begin
					result_fails++;
					$display("write-back of 0x%08h seen after the model ran out of results",
						result_w);
				end else begin
					exp_res = exp_res_q.pop_front();
					if (result_w !== exp_res) begin
						result_fails++;
						$display("FAIL result_w: got 0x%08h, expected 0x%08h", result_w, exp_res);
					end
				end
			end
			// advance the stage shadows
			stall      = load_use(instr_d, instr_e);
			prev_pc    = pc_f;
			prev_stall = stall;
			have_prev  = 1'b1;
			instr_w    = instr_m;
			instr_m    = instr_e;
			if (stall) begin
				instr_e = '0;                    // bubble while decode holds
			end else begin
				instr_e = instr_d;
				instr_d = instr_f;
			end
			cyc++;
		end
	end

	task automatic report_results(output int n_fail);
		int count_fails;
		count_fails = (n_seen != n_expected || exp_addr_q.size() != 0) ? 1 : 0;
		if (count_fails != 0)
			$display("store count wrong, saw %0d stores but the model made %0d",
				n_seen, n_expected);
		if (exp_res_q.size() != 0) begin
			result_fails++;
			$display("%0d register results never reached writeback", exp_res_q.size());
		end
		$display("test pc_steps    : %s, %0d checks", verdict(pc_fails), pc_checks);
		$display("test stores      : %s, %0d stores compared", verdict(store_fails), n_seen);
		$display("test results     : %s, %0d values compared",
			verdict(result_fails), result_checks);
		$display("test store_count : %s, %0d of %0d", verdict(count_fails), n_seen, n_expected);
		n_fail = reset_fails + pc_fails + store_fails + result_fails + count_fails;
		$display("checks %0d, failures %0d, stores %0d of %0d",
			reset_checks + pc_checks + n_seen + result_checks + 1, n_fail, n_seen, n_expected);
	endtask

endmodule

`default_nettype wire

// ==== mips_tb.sv ====
// testbench for the pipelined MIPS core with a random program, memory models and an ISA model
// the model hands its stores and register results to mips_checker for comparison
`default_nettype none

`include "mips_defs.svh"

module mips_tb;

	timeunit 1ns;
	timeprecision 1ps;

	logic                  clk;
	logic                  rst;
	logic [`MIPS_XLEN-1:0] instr_f    = '0;   // imem word at pc_f
	logic [`MIPS_XLEN-1:0] readdata_m = '0;   // dmem word at aluout_m
	logic [`MIPS_XLEN-1:0] pc_f, aluout_m, writedata_m, result_w;
	logic                  memwrite_m;
	int                    stores_seen, stores_expected;

	logic [`MIPS_XLEN-1:0] imem [512];        // program words
	logic [`MIPS_XLEN-1:0] dmem [256];        // 1 KiB data space
	int                    prog_len;
	integer                seed;              // $random state

	////////////////////////////////////////////////////////////
	// clock, DUT and checker
	////////////////////////////////////////////////////////////
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;               // 100 ns period
	end

	mips_pipeline mips_pipeline_inst (
		.clk         (clk),
		.rst         (rst),
		.instr_f     (instr_f),
		.readdata_m  (readdata_m),
		.pc_f        (pc_f),
		.memwrite_m  (memwrite_m),
		.aluout_m    (aluout_m),
		.writedata_m (writedata_m),
		.result_w    (result_w)
	);

	mips_checker checker_inst (
		.clk             (clk),
		.rst             (rst),
		.pc_f            (pc_f),
		.instr_f         (instr_f),
		.memwrite_m      (memwrite_m),
		.aluout_m        (aluout_m),
		.writedata_m     (writedata_m),
		.result_w        (result_w),
		.stores_seen     (stores_seen),
		.stores_expected (stores_expected)
	);

	// memories answer 1 ns after the edge once pc_f and aluout_m have settled
	always @(posedge clk) begin
		#1;
		instr_f = imem[pc_f[10:2]];
		if (memwrite_m === 1'b1)
			dmem[aluout_m[9:2]] = writedata_m;  // sw in memory stage
		readdata_m = dmem[aluout_m[9:2]];
	end

	////////////////////////////////////////////////////////////
	// program generation and ISA model
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] fill_word(input logic [7:0] idx);
		logic [31:0] addr;
		addr = {22'd0, idx, 2'b00};             // full byte address
		return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
	endfunction

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic logic [31:0] encode_r(input logic [5:0] funct,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd);
		return {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] encode_i(input logic [5:0] op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic gen_program();
		logic [31:0] w, w2;
		logic [4:0]  rs, rt, rd;
		for (int i = 0; i < 512; i++)
			imem[i] = '0;                       // zero word is a no-op
		prog_len = 0;
		for (int r = 1; r < 32; r++) begin      // seed every register
			w = rand_word();
			imem[prog_len] = encode_i(`MIPS_OP_ADDI, 5'd0, 5'(r), w[15:0]);
			prog_len++;
		end
		for (int i = 0; i < 200; i++) begin
			w  = rand_word();
			w2 = rand_word();                   // immediate or offset
			rs = w[25:21];
			rt = w[20:16];
			rd = w[15:11];
			case (w[2:0])
				3'd0: imem[prog_len] = encode_r(`MIPS_FN_AND, rs, rt, rd);
				3'd1: imem[prog_len] = encode_r(`MIPS_FN_OR, rs, rt, rd);
				3'd2: imem[prog_len] = encode_r(`MIPS_FN_ADD, rs, rt, rd);
				3'd3: imem[prog_len] = encode_r(`MIPS_FN_SUB, rs, rt, rd);
				3'd4: imem[prog_len] = encode_r(`MIPS_FN_SLT, rs, rt, rd);
				3'd5: imem[prog_len] = encode_i(`MIPS_OP_ADDI, rs, rt, w2[15:0]);
				3'd6: imem[prog_len] = encode_i(`MIPS_OP_LW, 5'd0, rt, {8'd0, w2[5:0], 2'b00});
				default: imem[prog_len] = encode_i(`MIPS_OP_SW, 5'd0, rt, {8'd0, w2[5:0], 2'b00});
			endcase
			prog_len++;
		end
		for (int r = 1; r < 33; r++) begin      // dump r1..r31 and finally r0
			rt = (r == 32) ? 5'd0 : 5'(r);
			imem[prog_len] = encode_i(`MIPS_OP_SW, 5'd0, rt, 16'(512 + 4 * (r - 1)));
			prog_len++;
		end
	endtask

	// runs the program one instruction at a time without a pipeline
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] mem [256];
		logic [31:0] w, a, b, simm, addr, val;
		logic [4:0]  dst;
		logic        wr;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = fill_word(8'(i));
		for (int i = 0; i < prog_len; i++) begin
			w    = imem[i];
			a    = regs[w[25:21]];
			b    = regs[w[20:16]];
			simm = {{16{w[15]}}, w[15:0]};
			addr = a + simm;
			wr   = 1'b1;
			dst  = w[20:16];                    // rt unless r-type
			val  = '0;
			case (w[31:26])
				`MIPS_OP_RTYPE: begin
					dst = w[15:11];
					case (w[5:0])
						`MIPS_FN_AND: val = a & b;
						`MIPS_FN_OR:  val = a | b;
						`MIPS_FN_ADD: val = a + b;
						`MIPS_FN_SUB: val = a - b;
						`MIPS_FN_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default:      wr = 1'b0;
					endcase
				end
				`MIPS_OP_ADDI: val = addr;
				`MIPS_OP_LW:   val = mem[addr[9:2]];
				`MIPS_OP_SW: begin
					wr = 1'b0;
					mem[addr[9:2]] = b;
					checker_inst.expect_store(addr, b);
				end
				default: wr = 1'b0;
			endcase
			if (wr) begin
				checker_inst.push_result(val);  // value seen on result_w in writeback
				if (dst != 5'd0)
					regs[dst] = val;            // r0 stays zero
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// run
	////////////////////////////////////////////////////////////
	initial begin : main
		int          cycles;
		int          n_fail;
		logic        timed_out;
		logic [31:0] end_pc;
		rst       = 1'b1;
		seed      = 9197;
		timed_out = 1'b0;
		for (int i = 0; i < 256; i++)
			dmem[i] = fill_word(8'(i));
		gen_program();
		run_model();
		end_pc = (prog_len + 6) * 4;            // last word fetched and drained
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		cycles = 0;
		while ((pc_f >= end_pc) !== 1'b1 && cycles < 2000) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if ((pc_f >= end_pc) !== 1'b1) begin
			$display("timeout: pc_f did not reach the end of the program in 2000 cycles");
			timed_out = 1'b1;
		end
		cycles = 0;
		while (!timed_out && stores_seen < stores_expected && cycles < 20) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!timed_out && stores_seen < stores_expected) begin
			$display("timeout: stores stopped at %0d of %0d", stores_seen, stores_expected);
			timed_out = 1'b1;
		end
		checker_inst.report_results(n_fail);
		if (timed_out || n_fail != 0)
			$display("sim failed");
		else
			$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
mips_pkg.sv
instr_decoder.sv
hazard_unit.sv
reg_file.sv
pipeline_datapath.sv
mips_pipeline.sv
mips_checker.sv
mips_tb.sv

// ==== Bender.yml ====
package:
  name: mips_pipeline

export_include_dirs:
  - .

sources:
  - mips_pkg.sv
  - instr_decoder.sv
  - hazard_unit.sv
  - reg_file.sv
  - pipeline_datapath.sv
  - mips_pipeline.sv
  - target: test
    files:
      - mips_checker.sv
      - mips_tb.sv
